// File: ifu_cfg_pkg.sv
package ifu_cfg_pkg;

   //****************************************
   // Address and data sizes
   //****************************************
   localparam int ADDR_W = 32;                          // Byte address
   localparam int WORD_W = 32;                          // One fetch word
   localparam int HW_W   = 16;                          // Halfword, shortest instruction

   localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_0040;   // First fetch, word aligned

   //****************************************
   // Branch target buffer geometry
   //****************************************
   localparam int BTB_ENTRIES = 16;
   localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);    // 4 index bits
   localparam int BTB_TAG_W   = 8;

   // Index and tag both come from the word address
   localparam int BTB_IDX_LO = 2;
   localparam int BTB_IDX_HI = BTB_IDX_LO + BTB_IDX_W - 1;
   localparam int BTB_TAG_LO = BTB_IDX_HI + 1;          // Bits right above the index
   localparam int BTB_TAG_HI = BTB_TAG_LO + BTB_TAG_W - 1;

   //****************************************
   // Fetch buffer
   //****************************************
   localparam int FB_DEPTH   = 6;                       // Halfwords
   localparam int FB_CNT_W   = $clog2(FB_DEPTH + 1);    // Occupancy 0..FB_DEPTH
   localparam int FB_RDY_MAX = FB_DEPTH - 4;            // Fill limit, F word included

endpackage

// File: ifu_pkt_pkg.sv
package ifu_pkt_pkg;

   import ifu_cfg_pkg::*;

   //****************************************
   // Branch prediction
   //****************************************
   typedef enum logic [1:0] {
      strong_nt,                                        // 2'b00
      weak_nt,
      weak_t,
      strong_t                                          // Saturates here
   } ctr_e;

   // Prediction for one fetch word, from the BTB in BF
   typedef struct packed {
      logic              taken;                         // Hit with taken-side counter
      logic              hw;                            // Branch starts at upper halfword
      logic [ADDR_W-1:0] target;                        // Halfword aligned
   } bp_pkt_t;

   // Training from execute, one-cycle strobe
   typedef struct packed {
      logic              valid;
      logic              taken;                         // Actual direction
      logic [ADDR_W-1:0] pc;                            // Branch first halfword
      logic [ADDR_W-1:0] target;
   } mp_pkt_t;

   //****************************************
   // Fetch to aligner
   //****************************************
   typedef struct packed {
      logic              valid;                         // Data present this cycle
      logic [ADDR_W-1:0] pc;                            // Word address, [1:0] zero
      logic              start_hw;                      // Entered at upper halfword
      logic [WORD_W-1:0] data;
      bp_pkt_t           bp;
   } fetch_pkt_t;

   //****************************************
   // Aligner to decode
   //****************************************
   typedef struct packed {
      logic              valid;
      logic [WORD_W-1:0] instr;                         // 16-bit zero-extended
      logic [HW_W-1:0]   cinst;                         // Raw 16-bit instruction
      logic [ADDR_W-1:0] pc;
      logic              pc4;                           // 32-bit instruction
      logic              pred_taken;
      logic [ADDR_W-1:0] pred_target;
   } i0_pkt_t;

endpackage

// File: ifu_fetch_ctl.sv
module ifu_fetch_ctl
   import ifu_cfg_pkg::*;
   import ifu_pkt_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              flush,                     // Redirect pulse from execute
   input  logic [ADDR_W-1:0] flush_path,                // Halfword address
   input  logic              bpred_disable,             // Level, ignore all predictions
   input  bp_pkt_t           bp_bf,                     // Same-cycle BTB result
   input  logic              fb_ready,                  // Aligner has room
   input  logic [WORD_W-1:0] iccm_rd_data,              // Returns one cycle after rden
   output logic [ADDR_W-1:0] fetch_addr_bf,
   output logic              iccm_rden,
   output logic [ADDR_W-1:0] iccm_rw_addr,
   output fetch_pkt_t        fetch_pkt
);

   logic [ADDR_W-1:0] fetch_addr_q, addr_nxt;           // BF halfword address
   logic [ADDR_W-1:0] next_word;
   logic              run_q;                            // Low until first edge after reset
   logic              redir_pend_q, pend_nxt;           // Target waits for tail word
   logic [ADDR_W-1:0] redir_tgt_q;
   logic              bp_use;

   // F stage copy of the request
   logic              req_f_q;
   logic [ADDR_W-1:0] pc_f_q;
   logic              start_hw_f_q;
   bp_pkt_t           bp_f_q;

   //****************************************
   // BF stage
   //****************************************
   assign fetch_addr_bf = fetch_addr_q;
   assign iccm_rden     = run_q & fb_ready & ~flush;    // No request in flush cycle
   assign iccm_rw_addr  = {fetch_addr_q[ADDR_W-1:2], 2'b00};
   assign next_word     = {fetch_addr_q[ADDR_W-1:2] + (ADDR_W-2)'(1), 2'b00};

   // Hit before the start halfword belongs to skipped code
   assign bp_use = bp_bf.taken & ~bpred_disable & ~redir_pend_q
                 & (bp_bf.hw | ~fetch_addr_q[1]);

   always_comb begin
      addr_nxt = fetch_addr_q;                          // Hold while stalled
      pend_nxt = redir_pend_q;
      if (flush) begin
         addr_nxt = {flush_path[ADDR_W-1:1], 1'b0};     // Bit 1 gives start_hw
         pend_nxt = 1'b0;
      end else if (iccm_rden) begin
         pend_nxt = 1'b0;
         if (redir_pend_q) begin
            addr_nxt = redir_tgt_q;                     // Tail word issued, now jump
         end else if (bp_use && !bp_bf.hw) begin
            addr_nxt = {bp_bf.target[ADDR_W-1:1], 1'b0};
         end else begin
            addr_nxt = next_word;
            pend_nxt = bp_use;                          // Upper-half branch may straddle
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fetch_addr_q <= RESET_PC;
         run_q        <= 1'b0;
         redir_pend_q <= 1'b0;
         req_f_q      <= 1'b0;
      end else begin
         fetch_addr_q <= addr_nxt;
         run_q        <= 1'b1;
         redir_pend_q <= pend_nxt;
         req_f_q      <= iccm_rden;
      end
   end

   always_ff @(posedge clk) begin
      if (iccm_rden && bp_use && bp_bf.hw) begin
         redir_tgt_q <= {bp_bf.target[ADDR_W-1:1], 1'b0};
      end
      if (iccm_rden) begin
         pc_f_q       <= iccm_rw_addr;
         start_hw_f_q <= fetch_addr_q[1];
         bp_f_q       <= '{taken: bp_use, hw: bp_bf.hw, target: bp_bf.target};
      end
   end

   //****************************************
   // F stage, pair request with data
   //****************************************
   always_comb begin
      fetch_pkt.valid    = req_f_q & ~flush;            // Killed by flush
      fetch_pkt.pc       = pc_f_q;
      fetch_pkt.start_hw = start_hw_f_q;
      fetch_pkt.data     = iccm_rd_data;
      fetch_pkt.bp       = bp_f_q;
   end

endmodule

// File: ifu_bpred.sv
module ifu_bpred
   import ifu_cfg_pkg::*;
   import ifu_pkt_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic [ADDR_W-1:0] fetch_addr_bf,             // BF halfword address
   input  mp_pkt_t           mp_pkt,                    // Training strobe from execute
   output bp_pkt_t           bp_bf
);

   typedef struct packed {
      logic [BTB_TAG_W-1:0] tag;
      logic                 hw;                         // Branch first halfword position
      logic [ADDR_W-1:0]    target;
      ctr_e                 ctr;
   } btb_ent_t;

   btb_ent_t               btb_q [BTB_ENTRIES];
   logic [BTB_ENTRIES-1:0] vld_q;

   logic [BTB_IDX_W-1:0] rd_idx, wr_idx;
   logic [BTB_TAG_W-1:0] rd_tag, wr_tag;
   btb_ent_t             rd_ent, wr_ent;
   logic                 rd_hit, mp_hit;

   function automatic ctr_e ctr_inc(input ctr_e c);
      ctr_e r;
      case (c)
         strong_nt: r = weak_nt;
         weak_nt:   r = weak_t;
         default:   r = strong_t;                       // Saturate
      endcase
      return r;
   endfunction

   function automatic ctr_e ctr_dec(input ctr_e c);
      ctr_e r;
      case (c)
         strong_t: r = weak_t;
         weak_t:   r = weak_nt;
         default:  r = strong_nt;                       // Saturate
      endcase
      return r;
   endfunction

   //****************************************
   // Lookup, combinational in BF
   //****************************************
   assign rd_idx = fetch_addr_bf[BTB_IDX_HI:BTB_IDX_LO];
   assign rd_tag = fetch_addr_bf[BTB_TAG_HI:BTB_TAG_LO];
   assign rd_ent = btb_q[rd_idx];
   assign rd_hit = vld_q[rd_idx] & (rd_ent.tag == rd_tag);

   always_comb begin
      bp_bf.taken  = rd_hit & ((rd_ent.ctr == weak_t) | (rd_ent.ctr == strong_t));
      bp_bf.hw     = rd_ent.hw;                         // Start_hw check is downstream
      bp_bf.target = rd_ent.target;
   end

   //****************************************
   // Training
   //****************************************
   assign wr_idx = mp_pkt.pc[BTB_IDX_HI:BTB_IDX_LO];
   assign wr_tag = mp_pkt.pc[BTB_TAG_HI:BTB_TAG_LO];
   assign wr_ent = btb_q[wr_idx];
   assign mp_hit = vld_q[wr_idx] & (wr_ent.tag == wr_tag) & (wr_ent.hw == mp_pkt.pc[1]);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         vld_q <= '0;
      end else if (mp_pkt.valid && mp_pkt.taken) begin
         vld_q[wr_idx] <= 1'b1;                         // Install or keep
      end
   end

   always_ff @(posedge clk) begin
      if (mp_pkt.valid) begin
         if (mp_pkt.taken) begin
            if (mp_hit) begin
               btb_q[wr_idx].ctr    <= ctr_inc(wr_ent.ctr);
               btb_q[wr_idx].target <= mp_pkt.target;   // Latest target wins
            end else begin
               btb_q[wr_idx] <= '{tag:    wr_tag,
                                  hw:     mp_pkt.pc[1],
                                  target: mp_pkt.target,
                                  ctr:    weak_t};      // New entry predicts taken
            end
         end else if (mp_hit) begin
            btb_q[wr_idx].ctr <= ctr_dec(wr_ent.ctr);   // Miss on not-taken leaves BTB alone
         end
      end
   end

endmodule

// File: ifu_aligner.sv
module ifu_aligner
   import ifu_cfg_pkg::*;
   import ifu_pkt_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       flush,
   input  fetch_pkt_t fetch_pkt,                        // F stage word
   input  logic       dec_i0_decode_d,                  // Decode took the offered instruction
   output logic       fb_ready,
   output i0_pkt_t    i0_pkt
);

   typedef struct packed {
      logic [HW_W-1:0]   data;
      logic [ADDR_W-1:0] pc;
      logic              pred;                          // Predicted-taken branch starts here
      logic [ADDR_W-1:0] tgt;
   } fb_ent_t;

   fb_ent_t [FB_DEPTH-1:0] fb_q, fb_sh, fb_n;           // Entry 0 is the head
   logic [FB_CNT_W-1:0]    cnt_q, cnt_n, cnt_pop, pos1, pop_cnt;
   logic [FB_CNT_W:0]      fill;
   logic                   tail_pend_q, tail_pend_n;    // Next word holds a branch tail
   logic                   tail_keep_q, tail_keep_n;    // Tail branch is 32-bit
   logic                   is32, head_ok;
   logic                   pred_ok, wr0, wr1;
   fb_ent_t                ent0, ent1;

   //****************************************
   // Write side
   //****************************************
   assign pred_ok = fetch_pkt.bp.taken & ~tail_pend_q
                  & (fetch_pkt.bp.hw | ~fetch_pkt.start_hw);

   always_comb begin
      ent0 = '{data: fetch_pkt.data[HW_W-1:0],
               pc:   fetch_pkt.pc,
               pred: pred_ok & ~fetch_pkt.bp.hw,
               tgt:  fetch_pkt.bp.target};
      ent1 = '{data: fetch_pkt.data[WORD_W-1:HW_W],
               pc:   {fetch_pkt.pc[ADDR_W-1:2], 2'b10},
               pred: pred_ok & fetch_pkt.bp.hw,
               tgt:  fetch_pkt.bp.target};
   end

   // Tail word keeps only the second half of a straddling branch
   assign wr0 = fetch_pkt.valid & ~flush
              & (tail_pend_q ? tail_keep_q : ~fetch_pkt.start_hw);
   assign wr1 = fetch_pkt.valid & ~flush & ~tail_pend_q
              & ~(pred_ok & ~fetch_pkt.bp.hw & (fetch_pkt.data[1:0] != 2'b11));

   always_comb begin
      tail_pend_n = tail_pend_q;
      tail_keep_n = tail_keep_q;
      if (flush) begin
         tail_pend_n = 1'b0;
      end else if (fetch_pkt.valid) begin
         tail_pend_n = ~tail_pend_q & pred_ok & fetch_pkt.bp.hw;
         tail_keep_n = fetch_pkt.data[HW_W+1:HW_W] == 2'b11;
      end
   end

   //****************************************
   // Read side
   //****************************************
   assign is32    = fb_q[0].data[1:0] == 2'b11;
   assign head_ok = (cnt_q != '0) & (~is32 | (cnt_q >= FB_CNT_W'(2)));
   assign pop_cnt = (dec_i0_decode_d & head_ok) ? (is32 ? FB_CNT_W'(2) : FB_CNT_W'(1)) : '0;

   always_comb begin
      i0_pkt.valid       = head_ok;
      i0_pkt.instr       = is32 ? {fb_q[1].data, fb_q[0].data} : {{HW_W{1'b0}}, fb_q[0].data};
      i0_pkt.cinst       = is32 ? '0 : fb_q[0].data;    // Raw compressed form
      i0_pkt.pc          = fb_q[0].pc;
      i0_pkt.pc4         = is32;
      i0_pkt.pred_taken  = fb_q[0].pred;
      i0_pkt.pred_target = fb_q[0].tgt;
   end

   //****************************************
   // Queue update
   //****************************************
   always_comb begin
      fb_sh   = fb_q >> (pop_cnt * $bits(fb_ent_t));    // Drop consumed halfwords
      cnt_pop = cnt_q - pop_cnt;
      pos1    = cnt_pop + FB_CNT_W'(wr0);               // Upper half lands after lower
      fb_n    = fb_sh;
      for (int i = 0; i < FB_DEPTH; i++) begin
         if (wr0 && (cnt_pop == FB_CNT_W'(i))) fb_n[i] = ent0;
         if (wr1 && (pos1 == FB_CNT_W'(i)))    fb_n[i] = ent1;
      end
      cnt_n = flush ? '0 : pos1 + FB_CNT_W'(wr1);       // Flush empties buffer
   end

   // Room for the F word and one more request
   assign fill     = {1'b0, cnt_q} + {{(FB_CNT_W-1){1'b0}}, fetch_pkt.valid, 1'b0};
   assign fb_ready = fill <= (FB_CNT_W+1)'(FB_RDY_MAX);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt_q       <= '0;
         tail_pend_q <= 1'b0;
         tail_keep_q <= 1'b0;
      end else begin
         cnt_q       <= cnt_n;
         tail_pend_q <= tail_pend_n;
         tail_keep_q <= tail_keep_n;
      end
   end

   always_ff @(posedge clk) begin
      fb_q <= fb_n;
   end

endmodule

// File: ifu_top.sv
module ifu_top
   import ifu_cfg_pkg::*;
   import ifu_pkt_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              exu_flush_final,           // Flush pulse
   input  logic [ADDR_W-1:0] exu_flush_path_final,      // Flush fetch address
   input  mp_pkt_t           exu_mp_pkt,                // BTB training
   input  logic              dec_tlu_bpred_disable,     // Disable all prediction
   input  logic              dec_i0_decode_d,           // Consume strobe
   input  logic [WORD_W-1:0] iccm_rd_data,
   output logic              iccm_rden,
   output logic [ADDR_W-1:0] iccm_rw_addr,
   output i0_pkt_t           i0_pkt
);

   logic [ADDR_W-1:0] fetch_addr_bf;
   bp_pkt_t           bp_bf;
   fetch_pkt_t        fetch_pkt;
   logic              fb_ready;

   ifu_fetch_ctl ifc (
      .clk           (clk),
      .arst_n        (arst_n),
      .flush         (exu_flush_final),
      .flush_path    (exu_flush_path_final),
      .bpred_disable (dec_tlu_bpred_disable),
      .bp_bf         (bp_bf),
      .fb_ready      (fb_ready),
      .iccm_rd_data  (iccm_rd_data),
      .fetch_addr_bf (fetch_addr_bf),
      .iccm_rden     (iccm_rden),
      .iccm_rw_addr  (iccm_rw_addr),
      .fetch_pkt     (fetch_pkt)
   );

   ifu_bpred bp (
      .clk           (clk),
      .arst_n        (arst_n),
      .fetch_addr_bf (fetch_addr_bf),
      .mp_pkt        (exu_mp_pkt),
      .bp_bf         (bp_bf)
   );

   ifu_aligner aln (
      .clk             (clk),
      .arst_n          (arst_n),
      .flush           (exu_flush_final),
      .fetch_pkt       (fetch_pkt),
      .dec_i0_decode_d (dec_i0_decode_d),
      .fb_ready        (fb_ready),
      .i0_pkt          (i0_pkt)
   );

endmodule

// File: tb_ifu_top.sv
module tb_ifu_top
   import ifu_cfg_pkg::*;
   import ifu_pkt_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   //****************************************
   // Test sizes and run limit
   //****************************************
   localparam int MEM_AW    = 8;                           // 1 KB instruction memory
   localparam int MEM_WORDS = 1 << MEM_AW;
   localparam int RST_CYC   = 16;
   localparam int N_SEQ     = 40;                          // Test 1 instructions
   localparam int N_FLUSH   = 20;                          // Per flush in test 2
   localparam int N_BR      = 30;                          // Tests 3 to 5
   localparam int N_STALL   = 40;                          // Test 6
   localparam int CYC_INS   = 4;                           // Cycles per instruction, free run
   localparam int CYC_STALL = 16;                          // Cycles per instruction, stalled
   localparam int TEST_CYC  = RST_CYC + CYC_INS * (N_SEQ + 2 * N_FLUSH + 3 * N_BR)
                            + CYC_STALL * N_STALL + 40;    // Plus train and flush cycles
   localparam int MAX_CYC   = 2 * TEST_CYC;

   localparam logic [ADDR_W-1:0] FLUSH_LO = 32'h0000_0100; // Word aligned path
   localparam logic [ADDR_W-1:0] FLUSH_HI = 32'h0000_01c2; // Upper halfword path
   localparam logic [ADDR_W-1:0] BR_TGT   = 32'h0000_0282;

   logic              clk = 1'b0;
   logic              arst_n;
   logic              exu_flush_final;
   logic [ADDR_W-1:0] exu_flush_path_final;
   mp_pkt_t           exu_mp_pkt;
   logic              dec_tlu_bpred_disable;
   logic              dec_i0_decode_d;
   logic [WORD_W-1:0] iccm_rd_data = '0;
   logic              iccm_rden;
   logic [ADDR_W-1:0] iccm_rw_addr;
   i0_pkt_t           i0_pkt;

   integer            seed = 32'h55cb_92ac;
   logic [31:0]       mem [MEM_WORDS];
   logic              rd_req = 1'b0;                       // Request seen last edge
   logic [MEM_AW-1:0] rd_addr = '0;
   int                errors = 0;
   int                tests_run = 0;
   int                tests_bad = 0;
   int                cyc = 0;

   // Walker state
   logic [ADDR_W-1:0] exp_pc, pc2, br_pc, br_pc_m, br_tgt;
   logic [31:0]       w0, w1;
   logic [15:0]       exp_hw0, exp_hw1;
   logic              exp_is32, exp_pred, take, br_vld, hold_q;
   logic [31:0]       exp_instr;
   logic [15:0]       exp_cinst;
   ctr_e              br_ctr;
   i0_pkt_t           prev_pkt;
   int                ncons, npred, nseen;
   logic [ADDR_W-1:0] seq_pcs [$];                         // Every consumed pc in order

   ifu_top uut (
      .clk                  (clk),
      .arst_n               (arst_n),
      .exu_flush_final      (exu_flush_final),
      .exu_flush_path_final (exu_flush_path_final),
      .exu_mp_pkt           (exu_mp_pkt),
      .dec_tlu_bpred_disable(dec_tlu_bpred_disable),
      .dec_i0_decode_d      (dec_i0_decode_d),
      .iccm_rd_data         (iccm_rd_data),
      .iccm_rden            (iccm_rden),
      .iccm_rw_addr         (iccm_rw_addr),
      .i0_pkt               (i0_pkt)
   );

   always #2 clk = ~clk;                                   // 4 ns period

   //****************************************
   // Memory model, one cycle read latency
   //****************************************
   always @(posedge clk) begin
      rd_req  <= iccm_rden;
      rd_addr <= iccm_rw_addr[MEM_AW+1:2];
   end

   always @(posedge clk) begin
      #0.5;
      iccm_rd_data = rd_req ? mem[rd_addr] : 32'h0;        // Idle bus reads as zero
   end

   //****************************************
   // Reference walker
   //****************************************
   assign pc2       = exp_pc + 32'd2;
   assign w0        = mem[exp_pc[MEM_AW+1:2]];
   assign w1        = mem[pc2[MEM_AW+1:2]];
   assign exp_hw0   = exp_pc[1] ? w0[31:16] : w0[15:0];
   assign exp_hw1   = pc2[1] ? w1[31:16] : w1[15:0];
   assign exp_is32  = exp_hw0[1:0] == 2'b11;               // Length from low two bits
   assign exp_instr = exp_is32 ? {exp_hw1, exp_hw0} : {16'h0, exp_hw0};
   assign exp_cinst = exp_is32 ? 16'h0 : exp_hw0;
   assign exp_pred  = br_vld && (exp_pc == br_pc_m) && !dec_tlu_bpred_disable
                    && ((br_ctr == weak_t) || (br_ctr == strong_t));
   assign take      = dec_i0_decode_d & i0_pkt.valid;

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exp_pc <= RESET_PC;
         ncons  <= 0;
         npred  <= 0;
         nseen  <= 0;
         br_vld <= 1'b0;
         br_ctr <= strong_nt;
         hold_q <= 1'b0;
      end else begin
         hold_q   <= i0_pkt.valid & ~dec_i0_decode_d & ~exu_flush_final;
         prev_pkt <= i0_pkt;
         if (exu_flush_final) begin
            exp_pc <= exu_flush_path_final;                // Restart at flush path
         end else if (take) begin
            exp_pc <= exp_pred ? br_tgt : exp_pc + (exp_is32 ? 32'd4 : 32'd2);
            ncons  <= ncons + 1;
            npred  <= npred + (exp_pred ? 1 : 0);
            nseen  <= nseen + ((exp_pc == br_pc) ? 1 : 0);
            seq_pcs.push_back(exp_pc);
         end
         if (exu_mp_pkt.valid) begin                       // Counter model
            if (exu_mp_pkt.taken) begin
               if (br_vld && exu_mp_pkt.pc == br_pc_m) begin
                  if (br_ctr != strong_t) br_ctr <= ctr_e'(br_ctr + 2'd1);
                  br_tgt <= exu_mp_pkt.target;
               end else begin
                  br_vld  <= 1'b1;                         // Fresh entry
                  br_pc_m <= exu_mp_pkt.pc;
                  br_tgt  <= exu_mp_pkt.target;
                  br_ctr  <= weak_t;
               end
            end else if (br_vld && exu_mp_pkt.pc == br_pc_m && br_ctr != strong_nt) begin
               br_ctr <= ctr_e'(br_ctr - 2'd1);
            end
         end
      end
   end

   //****************************************
   // Checks
   //****************************************
   a_pc: assert property (@(posedge clk) disable iff (!arst_n) take |-> i0_pkt.pc == exp_pc)
      else mismatch("i0_pkt.pc", 128'($sampled(i0_pkt.pc)), 128'($sampled(exp_pc)));
   a_instr: assert property (@(posedge clk) disable iff (!arst_n)
                             take |-> i0_pkt.instr == exp_instr)
      else mismatch("i0_pkt.instr", 128'($sampled(i0_pkt.instr)), 128'($sampled(exp_instr)));
   a_cinst: assert property (@(posedge clk) disable iff (!arst_n)
                             take |-> i0_pkt.cinst == exp_cinst)
      else mismatch("i0_pkt.cinst", 128'($sampled(i0_pkt.cinst)), 128'($sampled(exp_cinst)));
   a_pc4: assert property (@(posedge clk) disable iff (!arst_n) take |-> i0_pkt.pc4 == exp_is32)
      else mismatch("i0_pkt.pc4", 128'($sampled(i0_pkt.pc4)), 128'($sampled(exp_is32)));
   a_pred: assert property (@(posedge clk) disable iff (!arst_n)
                            take |-> i0_pkt.pred_taken == exp_pred)
      else mismatch("i0_pkt.pred_taken", 128'($sampled(i0_pkt.pred_taken)),
                    128'($sampled(exp_pred)));
   a_tgt: assert property (@(posedge clk) disable iff (!arst_n)
                           take && exp_pred |-> i0_pkt.pred_target == br_tgt)
      else mismatch("i0_pkt.pred_target", 128'($sampled(i0_pkt.pred_target)),
                    128'($sampled(br_tgt)));
   a_hold: assert property (@(posedge clk) disable iff (!arst_n) hold_q |-> i0_pkt == prev_pkt)
      else mismatch("i0_pkt", 128'($sampled(i0_pkt)), 128'($sampled(prev_pkt)));
   a_rst: assert property (@(posedge clk) !arst_n |-> !iccm_rden && !i0_pkt.valid)
      else note_failure("Fetch request or valid instruction while in reset");
   // First request right after reset goes to the reset vector
   a_first: assert property (@(posedge clk) $rose(arst_n) |=>
                             iccm_rden && iccm_rw_addr == RESET_PC)
      else note_failure("First fetch after reset missing or not at the reset vector");

   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= MAX_CYC) begin                            // Hung handshake
         $display("Timeout: run stopped after %0d cycles", cyc);
         $display("Checks failed");
         $finish;
      end
   end

   task automatic mismatch(input string name, input logic [127:0] got, input logic [127:0] exp);
      $display("Mismatch at %0.1f ns: %s got %0h expected %0h", $realtime, name, got, exp);
      errors++;
   endtask

   task automatic note_failure(input string msg);
      $display("At %0.1f ns: %s", $realtime, msg);
      errors++;
   endtask

   function automatic int rand_bits(input int mask);
      return $random(seed) & mask;
   endfunction

   task automatic step();
      @(posedge clk);
      #0.5;                                                // Drive after the edge
   endtask

   task automatic run_insns(input int n);
      int target;
      target = ncons + n;
      dec_i0_decode_d = 1'b1;
      do begin
         step();
      end while (ncons < target);
      dec_i0_decode_d = 1'b0;
   endtask

   task automatic run_stalled(input int n);
      int target;
      target = ncons + n;
      while (ncons < target) begin
         dec_i0_decode_d = 1'b0;                           // Decode busy
         repeat (1 + rand_bits(7)) step();
         dec_i0_decode_d = 1'b1;
         repeat (1 + rand_bits(3)) step();
      end
      dec_i0_decode_d = 1'b0;
   endtask

   task automatic redirect(input logic [ADDR_W-1:0] path);
      exu_flush_final      = 1'b1;
      exu_flush_path_final = path;
      step();
      exu_flush_final      = 1'b0;
   endtask

   task automatic train(input logic [ADDR_W-1:0] pc, input logic [ADDR_W-1:0] tgt,
                        input logic tk);
      exu_mp_pkt = '{valid: 1'b1, taken: tk, pc: pc, target: tgt};
      step();
      exu_mp_pkt = '0;
   endtask

   task automatic finish_test(input string name, input int err0);
      tests_run++;
      if (errors == err0) begin
         $display("Test %0d %s: ok", tests_run, name);
      end else begin
         tests_bad++;
         $display("Test %0d %s: %0d errors", tests_run, name, errors - err0);
      end
   endtask

   //****************************************
   // Stimulus
   //****************************************
   initial begin
      int e0;
      int p0;
      int s0;
      arst_n                = 1'b0;
      exu_flush_final       = 1'b0;
      exu_flush_path_final  = '0;
      exu_mp_pkt            = '0;
      dec_tlu_bpred_disable = 1'b0;
      dec_i0_decode_d       = 1'b0;
      br_pc                 = '0;
      for (int i = 0; i < MEM_WORDS; i++) mem[i] = $random(seed);
      repeat (RST_CYC) @(posedge clk);
      #0.5;
      arst_n = 1'b1;

      e0 = errors;
      run_insns(N_SEQ);
      finish_test("sequential fetch from reset", e0);
      br_pc = seq_pcs[12];                                 // Real instruction start

      e0 = errors;
      redirect(FLUSH_LO);
      run_insns(N_FLUSH);
      redirect(FLUSH_HI);
      run_insns(N_FLUSH);
      finish_test("flush redirect", e0);

      e0 = errors;
      p0 = npred;
      train(br_pc, BR_TGT, 1'b1);                          // Installs at weak taken
      redirect(RESET_PC);
      run_insns(N_BR);
      if (npred != p0 + 1) note_failure("Trained branch was not reached as predicted taken");
      finish_test("taken prediction", e0);

      e0 = errors;
      s0 = nseen;
      train(br_pc, BR_TGT, 1'b0);
      train(br_pc, BR_TGT, 1'b0);                          // Down to strong not taken
      redirect(RESET_PC);
      run_insns(N_BR);
      if (nseen == s0) note_failure("Branch was not reached after not-taken training");
      finish_test("not-taken training", e0);

      e0 = errors;
      s0 = nseen;
      train(br_pc, BR_TGT, 1'b1);
      train(br_pc, BR_TGT, 1'b1);                          // Back to weak taken
      dec_tlu_bpred_disable = 1'b1;
      redirect(RESET_PC);
      run_insns(N_BR);
      if (nseen == s0) note_failure("Branch was not reached with prediction disabled");
      dec_tlu_bpred_disable = 1'b0;
      finish_test("prediction disable", e0);

      e0 = errors;
      p0 = npred;
      redirect(RESET_PC);
      run_stalled(N_STALL);
      if (npred == p0) note_failure("Predicted branch was not reached under stalls");
      finish_test("decode back-pressure", e0);

      $display("Tests: %0d run, %0d failed, %0d instructions consumed, %0d errors",
               tests_run, tests_bad, ncons, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: ifu_top.f
ifu_cfg_pkg.sv
ifu_pkt_pkg.sv
ifu_fetch_ctl.sv
ifu_bpred.sv
ifu_aligner.sv
ifu_top.sv
tb_ifu_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_ifu_top
FLIST     = ifu_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Checks failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
